//--- filelist.f
hdl/pwmPkg.sv
hdl/ckeGenerator.sv
hdl/pwmCmdDecoder.sv
hdl/dutyFifo.sv
hdl/dutyGenerator.sv
hdl/pwmPlayerTop.sv
sim/pwmPlayer_asserts.sv
sim/pwmPlayerTb.sv

//--- hdl/ckeGenerator.sv
/*
  One-cycle clock enable every (interval + 1) clocks.
  A new interval is picked up only at the next wrap.
  Held at zero while enable is low; first cke comes on the first enabled cycle.
*/
`default_nettype none

module ckeGenerator
(
	input  wire logic                             iClk,
	input  wire logic                             rstN,
	input  wire logic                             enable,	// Level, clears divider when low
	input  wire logic [pwmPkg::intervalWidth-1:0] interval,
	output logic                                  cke
);

	import pwmPkg::*;

	logic [intervalWidth-1:0] divCnt;	// Down counter

	// Wrap when the count runs out
	assign cke = enable && (divCnt == '0);

	always_ff @(posedge iClk or negedge rstN)
	begin
		if (!rstN)
		begin
			divCnt <= '0;
		end
		else if (!enable)
		begin
			divCnt <= '0;	// Hold at zero while disabled
		end
		else if (cke)
		begin
			divCnt <= interval;	// Reload at wrap only
		end
		else
		begin
			divCnt <= divCnt - 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- hdl/dutyFifo.sv
/*
  First-word fall-through FIFO for duty samples.
  pFifoDepth must be a power of two and at least 2.
  Writes into a full FIFO are lost and flagged on dropped.
*/
`default_nettype none

module dutyFifo #(
	parameter int pFifoDepth = 8
)
(
	input  wire logic                iClk,
	input  wire logic                rstN,
	input  wire logic                wrEn,
	input  wire pwmPkg::dutySample_s wrData,
	input  wire logic                popEn,	// Advance read side
	output pwmPkg::dutySample_s      rdData,	// Valid whenever not empty
	output logic                     empty,
	output logic                     full,
	output logic                     dropped	// One pulse per lost write
);

	import pwmPkg::*;

	localparam int addrWidth = $clog2(pFifoDepth);

	// --------------------------------------------------
	// Storage and pointers
	// --------------------------------------------------
	dutySample_s          mem [pFifoDepth];
	logic [addrWidth:0]   wrPtr;	// MSB is the wrap bit
	logic [addrWidth:0]   rdPtr;
	logic                 doWrite;
	logic                 doPop;

	// Same address, wrap bits apart means full
	assign empty = (wrPtr == rdPtr);
	assign full  = (wrPtr[addrWidth] != rdPtr[addrWidth]) &&
		(wrPtr[addrWidth-1:0] == rdPtr[addrWidth-1:0]);

	assign doWrite = wrEn && !full;
	assign doPop   = popEn && !empty;	// Guard against stray pops
	assign dropped = wrEn && full;

	// Head of queue straight from the array
	assign rdData = mem[rdPtr[addrWidth-1:0]];

	always_ff @(posedge iClk)
	begin
		if (doWrite)
		begin
			mem[wrPtr[addrWidth-1:0]] <= wrData;
		end
	end

	// --------------------------------------------------
	// Pointer update
	// --------------------------------------------------
	always_ff @(posedge iClk or negedge rstN)
	begin
		if (!rstN)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
		end
		else
		begin
			if (doWrite)
			begin
				wrPtr <= wrPtr + 1'b1;
			end
			if (doPop)
			begin
				rdPtr <= rdPtr + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/dutyGenerator.sv
/*
  PWM core with one 8-bit duty sweep per period.
  Output is high while duty < counter, so high time is (255 - duty) steps.
  A new sample is taken at each period end; an empty FIFO repeats the last duty.
*/
`default_nettype none

module dutyGenerator
(
	input  wire logic                             iClk,
	input  wire logic                             rstN,
	input  wire logic                             enable,
	input  wire logic [pwmPkg::intervalWidth-1:0] interval,
	input  wire pwmPkg::dutySample_s              rdData,	// FIFO head
	input  wire logic                             empty,
	output logic                                  popEn,
	output logic                                  pwm,
	output logic                                  cycleDone,	// End of period pulse
	output logic                                  burstEnd
);

	import pwmPkg::*;

	// --------------------------------------------------
	// Time base
	// --------------------------------------------------
	logic                 cke;
	logic [dutyWidth-1:0] dutyCnt;	// Step within the period
	logic [dutyWidth-1:0] duty;	// Sample now playing
	logic                 periodEnd;

	ckeGenerator ckeGen
	(
		.iClk     (iClk),
		.rstN     (rstN),
		.enable   (enable),
		.interval (interval),
		.cke      (cke)
	);

	// Last step of the sweep is finishing
	assign periodEnd = cke && (dutyCnt == dutyMax);

	// Fetch next sample in the cycle after the wrap
	assign popEn = cycleDone && !empty;

	always_ff @(posedge iClk or negedge rstN)
	begin
		if (!rstN)
		begin
			dutyCnt <= '0;
		end
		else if (!enable)
		begin
			dutyCnt <= '0;
		end
		else if (cke)
		begin
			dutyCnt <= dutyCnt + 1'b1;	// Wraps 255 -> 0
		end
	end

	// --------------------------------------------------
	// Registered outputs and duty update
	// --------------------------------------------------
	always_ff @(posedge iClk or negedge rstN)
	begin
		if (!rstN)
		begin
			pwm       <= 1'b0;
			cycleDone <= 1'b0;
			burstEnd  <= 1'b0;
			duty      <= '0;
		end
		else
		begin
			pwm       <= enable && (duty < dutyCnt);	// Low at counter zero
			cycleDone <= periodEnd;
			burstEnd  <= popEn && rdData.lastOfBurst;	// Marked sample starts
			if (popEn)
			begin
				duty <= rdData.duty;	// Counter already at zero here
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/pwmCmdDecoder.sv
/*
  Splits host command words into FIFO writes and interval updates.
  iCmd is sampled only on the iCmdValid strobe.
  Both outputs change one clock after the strobe.
*/
`default_nettype none

module pwmCmdDecoder
(
	input  wire logic                             iClk,
	input  wire logic                             rstN,
	input  wire logic                             iCmdValid,	// One-cycle strobe
	input  wire pwmPkg::pwmCmd_u                  iCmd,
	output logic                                  wrEn,	// FIFO write strobe
	output pwmPkg::dutySample_s                   wrData,
	output logic [pwmPkg::intervalWidth-1:0]      interval	// Level to divider
);

	import pwmPkg::*;

	// --------------------------------------------------
	// Command classification
	// --------------------------------------------------
	cmdKind_e cmdKind;
	logic     isDutyCmd;
	logic     isIntervalCmd;

	// Kind bit is shared by both views
	assign cmdKind       = iCmd.dutyView.kind;
	assign isDutyCmd     = iCmdValid && (cmdKind == kindDuty);
	assign isIntervalCmd = iCmdValid && (cmdKind == kindInterval);

	// --------------------------------------------------
	// Control registers
	// --------------------------------------------------
	always_ff @(posedge iClk or negedge rstN)
	begin
		if (!rstN)
		begin
			wrEn     <= 1'b0;
			interval <= '0;	// Fastest time base after reset
		end
		else
		begin
			wrEn <= isDutyCmd;	// Single pulse per duty command
			if (isIntervalCmd)
			begin
				interval <= iCmd.intervalView.interval;
			end
		end
	end

	// --------------------------------------------------
	// Sample payload
	// --------------------------------------------------
	always_ff @(posedge iClk)
	begin
		if (isDutyCmd)
		begin
			wrData.duty        <= iCmd.dutyView.duty;
			wrData.lastOfBurst <= iCmd.dutyView.reserved[burstFlagBit];	// Word bit 14
		end
	end

endmodule

`default_nettype wire

//--- hdl/pwmPkg.sv
/*
  Shared widths and types for the PWM player.
  The command word layout is tied to dutyWidth = 8 and cmdWidth = 16.
  Duty commands carry the burst marker in word bit 14.
*/
`default_nettype none

package pwmPkg;

	// --------------------------------------------------
	// Widths and limits
	// --------------------------------------------------
	localparam int dutyWidth     = 8;	// Duty resolution
	localparam int intervalWidth = 15;	// Clock enable divider
	localparam int cmdWidth      = 16;	// Host command word
	localparam int burstFlagBit  = 6;	// Bit 14 of the word, inside reserved

	// Top of the duty counter
	localparam logic [dutyWidth-1:0] dutyMax = '1;

	// --------------------------------------------------
	// Host command word
	// --------------------------------------------------
	// Kind bit is always word bit 15
	typedef enum logic
	{
		kindDuty     = 1'b0,	// Sample for the FIFO
		kindInterval = 1'b1	// New PWM time base
	} cmdKind_e;

	typedef struct packed
	{
		cmdKind_e                          kind;
		logic [cmdWidth-dutyWidth-2:0]     reserved;	// Only the burst bit is read
		logic [dutyWidth-1:0]              duty;
	} dutyCmd_s;

	typedef struct packed
	{
		cmdKind_e                          kind;
		logic [intervalWidth-1:0]          interval;	// Divider reload value
	} intervalCmd_s;

	// Same 16 bits, two readings selected by kind
	typedef union packed
	{
		dutyCmd_s                          dutyView;
		intervalCmd_s                      intervalView;
	} pwmCmd_u;

	// --------------------------------------------------
	// FIFO payload
	// --------------------------------------------------
	typedef struct packed
	{
		logic                              lastOfBurst;	// Marks end of a host burst
		logic [dutyWidth-1:0]              duty;
	} dutySample_s;

endpackage

`default_nettype wire

//--- hdl/pwmPlayerTop.sv
/*
  PWM sample player. Host command decoder feeds a duty FIFO
  that the PWM generator drains once per period.
  oDropped pulses for each duty command lost to a full FIFO.
*/
`default_nettype none

module pwmPlayerTop #(
	parameter int pFifoDepth = 8	// Power of two
)
(
	input  wire logic            iClk,
	input  wire logic            rstN,
	input  wire logic            iEnable,	// Level, PWM runs while high
	input  wire logic            iCmdValid,
	input  wire pwmPkg::pwmCmd_u iCmd,
	output logic                 oPwm,
	output logic                 oCycleDone,
	output logic                 oBurstEnd,
	output logic                 oFifoFull,
	output logic                 oDropped
);

	import pwmPkg::*;

	// --------------------------------------------------
	// Internal links
	// --------------------------------------------------
	logic                     wrEn;	// Decoder to FIFO
	dutySample_s              wrData;
	logic [intervalWidth-1:0] interval;	// Decoder to generator
	logic                     popEn;	// Generator to FIFO
	dutySample_s              rdData;
	logic                     fifoEmpty;

	pwmCmdDecoder cmdDecoder
	(
		.iClk      (iClk),
		.rstN      (rstN),
		.iCmdValid (iCmdValid),
		.iCmd      (iCmd),
		.wrEn      (wrEn),
		.wrData    (wrData),
		.interval  (interval)
	);

	dutyFifo #(
		.pFifoDepth (pFifoDepth)
	) sampleFifo
	(
		.iClk    (iClk),
		.rstN    (rstN),
		.wrEn    (wrEn),
		.wrData  (wrData),
		.popEn   (popEn),
		.rdData  (rdData),
		.empty   (fifoEmpty),
		.full    (oFifoFull),
		.dropped (oDropped)
	);

	dutyGenerator pwmGen
	(
		.iClk      (iClk),
		.rstN      (rstN),
		.enable    (iEnable),
		.interval  (interval),
		.rdData    (rdData),
		.empty     (fifoEmpty),
		.popEn     (popEn),
		.pwm       (oPwm),
		.cycleDone (oCycleDone),
		.burstEnd  (oBurstEnd)
	);

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build and run the PWM player testbench with Verilator.
# Exits non-zero if the build fails, the simulator fails, or the log
# holds the testbench fail message.

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log
failMsg="FAIL: see errors above"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	--top-module pwmPlayerTb --Mdir "$buildDir" -o pwmPlayerSim -f filelist.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$buildDir/pwmPlayerSim" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"

if grep -q "$failMsg" "$logFile"; then
	echo "Simulation reported a failure"
	exit 1
fi

if [ $simStatus -ne 0 ]; then
	echo "Simulator exited with status $simStatus"
	exit 1
fi

echo "Simulation finished without failures"
exit 0

//--- sim/pwmPlayerTb.sv
/*
  Table-driven testbench for the PWM player at FIFO depth 8.
  Each table row is written during one period and measured in the next.
  High time and period length are counted between oCycleDone pulses.
*/
`default_nettype none

module pwmPlayerTb;

	timeunit 1ns;
	timeprecision 1ps;

	import pwmPkg::*;

	localparam int clkPeriod   = 10;
	localparam int fifoDepth   = 8;
	localparam int extraWrites = 3;	// Writes past a full FIFO
	localparam int numRows     = 8;

	// --------------------------------------------------
	// Stimulus table
	// --------------------------------------------------
	typedef struct packed
	{
		logic [7:0]  duty;
		logic [14:0] interval;
		logic        burst;	// Word bit 14 of the duty command
	} stimRow_s;

	stimRow_s stimTable [numRows] = '{
		'{8'd40,  15'd0, 1'b0},
		'{8'd255, 15'd0, 1'b0},	// Never high
		'{8'd0,   15'd0, 1'b1},
		'{8'd128, 15'd1, 1'b0},
		'{8'd200, 15'd1, 1'b1},
		'{8'd250, 15'd3, 1'b0},
		'{8'd17,  15'd2, 1'b0},
		'{8'd99,  15'd0, 1'b0}	// Back to the fastest base for the FIFO test
	};

	logic    iClk;
	logic    rstN;
	logic    iEnable;
	logic    iCmdValid;
	pwmCmd_u iCmd;
	logic    oPwm;
	logic    oCycleDone;
	logic    oBurstEnd;
	logic    oFifoFull;
	logic    oDropped;

	int      errorCount   = 0;
	int      dropCount    = 0;	// Running total of oDropped pulses
	bit      failReported = 1'b0;
	bit      runDone      = 1'b0;
	integer  seed         = 26991;

	pwmPlayerTop #(
		.pFifoDepth (fifoDepth)
	) dut_i
	(
		.iClk       (iClk),
		.rstN       (rstN),
		.iEnable    (iEnable),
		.iCmdValid  (iCmdValid),
		.iCmd       (iCmd),
		.oPwm       (oPwm),
		.oCycleDone (oCycleDone),
		.oBurstEnd  (oBurstEnd),
		.oFifoFull  (oFifoFull),
		.oDropped   (oDropped)
	);

	initial
	begin
		iClk = 1'b0;
		forever #(clkPeriod / 2) iClk = ~iClk;
	end

	always @(negedge iClk)
	begin
		if (oDropped)
		begin
			dropCount++;
		end
	end

	// --------------------------------------------------
	// Helpers
	// --------------------------------------------------
	task automatic checkValue(input string testName, input int expected, input int actual);
		if (expected != actual)
		begin
			errorCount++;
			failReported = 1'b1;
			$display("[FAIL] %s: expected %0d, actual %0d", testName, expected, actual);
			$display("FAIL: see errors above");
			$fatal(1, "Stopping at first mismatch");
		end
	endtask

	// Kind 0, burst in bit 14, duty in the low byte
	function automatic logic [15:0] dutyWord(input logic [7:0] duty, input logic burst);
		return {1'b0, burst, 6'b0, duty};
	endfunction

	function automatic logic [15:0] intervalWord(input logic [14:0] interval);
		return {1'b1, interval};
	endfunction

	task automatic sendCmd(input logic [15:0] word);
		@(posedge iClk);
		iCmdValid <= 1'b1;
		iCmd      <= word;
		@(posedge iClk);
		iCmdValid <= 1'b0;	// One-cycle strobe
	endtask

	// Counts from the cycle after a period start up to the next oCycleDone
	task automatic measurePeriod(output int highCnt, output int periodLen, output int burstCnt);
		highCnt   = 0;
		periodLen = 0;
		burstCnt  = 0;
		do
		begin
			@(negedge iClk);
			periodLen++;
			if (oPwm)
			begin
				highCnt++;
			end
			if (oBurstEnd)
			begin
				burstCnt++;
			end
		end
		while (!oCycleDone);
	endtask

	task automatic checkPeriod(input string testName, input int duty, input int interval,
		input int bursts, input int highCnt, input int periodLen, input int burstCnt);
		int steps;
		steps = interval + 1;	// Clocks per counter step
		checkValue({testName, " period length"}, 256 * steps, periodLen);
		checkValue({testName, " high time"}, (255 - duty) * steps, highCnt);
		checkValue({testName, " burst pulses"}, bursts, burstCnt);
	endtask

	function automatic int runCycles();
		int cycles;
		cycles = 256;	// First period after enable
		foreach (stimTable[i])
		begin
			cycles += 2 * 256 * (int'(stimTable[i].interval) + 1);	// Lead and play
		end
		cycles += (fifoDepth + 3) * 256;	// Fill, drain, repeats
		cycles += 2 * 256 + 1000;
		return cycles;
	endfunction

	// --------------------------------------------------
	// Watchdog
	// --------------------------------------------------
	initial
	begin
		#(runCycles() * clkPeriod);
		failReported = 1'b1;
		$display("Watchdog timeout: the DUT stopped ending PWM periods");
		$display("FAIL: see errors above");
		$fatal(1, "Run time limit reached");
	end

	// Run cut short by a failed assertion
	final
	begin
		if (!runDone && !failReported)
		begin
			$display("FAIL: see errors above");
		end
	end

	// --------------------------------------------------
	// Test sequence
	// --------------------------------------------------
	initial
	begin
		int         highCnt;
		int         periodLen;
		int         burstCnt;
		int         curInterval;
		int         dropsBefore;
		int         markIdx;
		bit         intervalChange;
		stimRow_s   row;
		logic [7:0] lastDuty;
		logic [7:0] fillDuty [fifoDepth + extraWrites];

		rstN        = 1'b0;
		iEnable     = 1'b0;
		iCmdValid   = 1'b0;
		iCmd        = '0;
		curInterval = 0;
		lastDuty    = 8'd0;	// Duty register after reset
		markIdx     = fifoDepth / 2;

		repeat (4) @(posedge iClk);
		rstN <= 1'b1;
		@(negedge iClk);
		checkValue("reset oPwm", 0, int'(oPwm));
		checkValue("reset oCycleDone", 0, int'(oCycleDone));
		checkValue("reset oDropped", 0, int'(oDropped));
		checkValue("reset oBurstEnd", 0, int'(oBurstEnd));
		checkValue("reset oFifoFull", 0, int'(oFifoFull));

		@(posedge iClk);
		iEnable <= 1'b1;
		@(negedge iClk);	// First enabled cycle, counter at zero
		measurePeriod(highCnt, periodLen, burstCnt);
		checkPeriod("first period", 0, 0, 0, highCnt, periodLen, burstCnt);

		// Write during the lead period, play in the next one
		foreach (stimTable[i])
		begin
			row            = stimTable[i];
			intervalChange = (int'(row.interval) != curInterval);
			fork
				measurePeriod(highCnt, periodLen, burstCnt);
				begin
					if (intervalChange)
					begin
						sendCmd(intervalWord(row.interval));
					end
					sendCmd(dutyWord(row.duty, row.burst));
				end
			join
			if (!intervalChange)	// Mixed time base otherwise
			begin
				checkPeriod($sformatf("row %0d repeat", i), int'(lastDuty), curInterval, 0,
					highCnt, periodLen, burstCnt);
			end
			measurePeriod(highCnt, periodLen, burstCnt);
			checkPeriod($sformatf("row %0d play", i), int'(row.duty), int'(row.interval),
				int'(row.burst), highCnt, periodLen, burstCnt);
			curInterval = int'(row.interval);
			lastDuty    = row.duty;
		end

		// --------------------------------------------------
		// FIFO overflow and playback
		// --------------------------------------------------
		for (int k = 0; k < fifoDepth + extraWrites; k++)
		begin
			fillDuty[k] = (k < fifoDepth) ? 8'(k * 37 + 11) : 8'($random(seed));
		end
		dropsBefore = dropCount;
		fork
			measurePeriod(highCnt, periodLen, burstCnt);
			begin
				for (int k = 0; k < fifoDepth + extraWrites; k++)
				begin
					sendCmd(dutyWord(fillDuty[k], 1'(k == markIdx)));
				end
				repeat (3) @(negedge iClk);
				checkValue("FIFO full flag", 1, int'(oFifoFull));
				checkValue("dropped writes", extraWrites, dropCount - dropsBefore);
			end
		join
		checkPeriod("fill lead repeat", int'(lastDuty), 0, 0, highCnt, periodLen, burstCnt);

		for (int k = 0; k < fifoDepth; k++)
		begin
			measurePeriod(highCnt, periodLen, burstCnt);
			checkPeriod($sformatf("FIFO sample %0d", k), int'(fillDuty[k]), 0,
				int'(k == markIdx), highCnt, periodLen, burstCnt);
		end
		checkValue("FIFO full after drain", 0, int'(oFifoFull));
		lastDuty = fillDuty[fifoDepth - 1];

		// Empty FIFO keeps the last sample
		repeat (2)
		begin
			measurePeriod(highCnt, periodLen, burstCnt);
			checkPeriod("empty FIFO repeat", int'(lastDuty), 0, 0, highCnt, periodLen, burstCnt);
		end

		// --------------------------------------------------
		// Disable in mid period
		// --------------------------------------------------
		repeat (100) @(negedge iClk);
		@(posedge iClk);
		iEnable <= 1'b0;
		@(negedge iClk);	// oPwm still holds its last enabled value
		repeat (20)
		begin
			@(negedge iClk);
			checkValue("oPwm while disabled", 0, int'(oPwm));
		end
		@(posedge iClk);
		iEnable <= 1'b1;
		@(negedge iClk);
		measurePeriod(highCnt, periodLen, burstCnt);
		checkPeriod("period after re-enable", int'(lastDuty), 0, 0, highCnt, periodLen, burstCnt);

		runDone = 1'b1;
		if (errorCount == 0)
		begin
			$display("PASS: all tests");
		end
		else
		begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- sim/pwmPlayer_asserts.sv
/*
  Concurrent checks bound into pwmPlayerTop.
  popEn and wrEn are internal nets of the top level.
  The FIFO fill level is tracked here from the strobes alone.
*/
`default_nettype none

module pwmPlayerAsserts #(
	parameter int pFifoDepth = 8
)
(
	input wire logic iClk,
	input wire logic rstN,
	input wire logic iEnable,
	input wire logic wrEn,	// Decoder to FIFO
	input wire logic popEn,	// Generator to FIFO
	input wire logic oDropped,
	input wire logic oPwm
);

	timeunit 1ns;
	timeprecision 1ps;

	localparam int levelWidth = $clog2(pFifoDepth) + 1;

	// --------------------------------------------------
	// Reference fill level
	// --------------------------------------------------
	logic [levelWidth-1:0] fillLevel;	// Samples held
	logic                  levelFull;
	logic                  wrTaken;
	logic                  popTaken;

	assign levelFull = (fillLevel == levelWidth'(pFifoDepth));
	assign wrTaken   = wrEn && !levelFull;	// Write that finds room
	assign popTaken  = popEn && (fillLevel != '0);

	always_ff @(posedge iClk or negedge rstN)
	begin
		if (!rstN)
		begin
			fillLevel <= '0;
		end
		else
		begin
			fillLevel <= fillLevel + levelWidth'(wrTaken) - levelWidth'(popTaken);
		end
	end

	// --------------------------------------------------
	// FIFO side
	// --------------------------------------------------
	popOnlyWhenFilled: assert property (@(posedge iClk) disable iff (!rstN)
		popEn |-> (fillLevel != '0))
	else
		$error("Pop issued while the FIFO was empty");

	dropOnlyWhenFull: assert property (@(posedge iClk) disable iff (!rstN)
		oDropped |-> levelFull)
	else
		$error("Dropped write reported while the FIFO was not full");

	// Sweep restarts at zero, so low for one more clock after re-enable
	pwmLowWhenDisabled: assert property (@(posedge iClk) disable iff (!rstN)
		(!iEnable || !$past(iEnable)) |=> !oPwm)
	else
		$error("PWM output high while disabled or right after re-enable");

endmodule

bind pwmPlayerTop pwmPlayerAsserts #(
	.pFifoDepth (pFifoDepth)
) pwmChecks
(
	.iClk      (iClk),
	.rstN      (rstN),
	.iEnable   (iEnable),
	.wrEn      (wrEn),
	.popEn     (popEn),
	.oDropped  (oDropped),
	.oPwm      (oPwm)
);

`default_nettype wire
